/* common/rv_pkg.sv */
`include "common/rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        op_r     = 7'b0110011,
        op_i     = 7'b0010011,
        op_s     = 7'b0100011,
        op_l     = 7'b0000011,
        op_b     = 7'b1100011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        from_alu = 2'd0,
        from_mem = 2'd1,
        from_pc  = 2'd2 // Link value pc + 4
    } wb_src_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } issue_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        alu_op_e   alu_op;
        logic      a_is_pc;
        logic      b_is_imm;
        logic [2:0] funct3;
        reg_addr_t rd;
        wb_src_e   wb_src;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      jal;
        logic      jalr;
        logic      illegal;
    } dec_op_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_res;    // Holds the link value for jumps
        word_t     store_data;
        word_t     next_pc;
        logic [2:0] funct3;
        reg_addr_t rd;
        wb_src_e   wb_src;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      illegal;
    } exe_res_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      rd_we;
        word_t     wdata;
        word_t     next_pc;
        logic      illegal;
    } retire_t;

endpackage

/* common/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path width, one RV32I word
`define RV_XLEN 32

// Register index, 32 architectural registers
`define RV_REG_ADDR_W 5

`define RV_DMEM_WORDS 256 // Private data memory depth in words

`endif

/* decode/rv_decode.sv */
`timescale 1ns/100ps
`include "common/rv_settings.svh"

module rv_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  rv_pkg::issue_t            issue,
    output logic                      issue_ready,
    output logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]       rs1_data,
    input  logic [`RV_XLEN-1:0]       rs2_data,
    input  logic                      wb_en,
    input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
    output logic                      dec_valid,
    output rv_pkg::dec_op_t           dec_op,
    input  logic                      dec_ready
);
    import rv_pkg::*;

    localparam int NUM_REGS = 1 << `RV_REG_ADDR_W;

    word_t                instr;
    opcode_e              opcode;
    logic [2:0]           funct3;
    reg_addr_t            rd;
    dec_op_t              op;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic [NUM_REGS-1:0]  busy_q;
    logic [NUM_REGS-1:0]  clr_mask;
    logic [NUM_REGS-1:0]  set_mask;
    logic [NUM_REGS-1:0]  busy_now;
    logic                 hazard;
    logic                 issue_fire;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic f7_5,
                                        input logic is_r);
        alu_op_e sel;
        case (f3)
            3'b000:  sel = (is_r && f7_5) ? alu_sub : alu_add;
            3'b001:  sel = alu_sll;
            3'b010:  sel = alu_slt;
            3'b011:  sel = alu_sltu;
            3'b100:  sel = alu_xor;
            3'b101:  sel = f7_5 ? alu_sra : alu_srl; // srai also uses bit 30
            3'b110:  sel = alu_or;
            default: sel = alu_and;
        endcase
        return sel;
    endfunction

    assign instr    = issue.instr;
    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        op         = '0; // Unknown opcodes keep every write flag clear
        op.pc      = issue.pc;
        op.rs1_val = rs1_data;
        op.rs2_val = rs2_data;
        op.funct3  = funct3;
        op.rd      = rd;
        op.alu_op  = alu_add;
        op.wb_src  = from_alu;
        uses_rs1   = 1'b1;
        uses_rs2   = 1'b0;
        case (opcode)
            op_r: begin
                op.reg_write = 1'b1;
                op.alu_op    = alu_sel(funct3, instr[30], 1'b1);
                uses_rs2     = 1'b1;
            end
            op_i: begin
                op.reg_write = 1'b1;
                op.b_is_imm  = 1'b1;
                op.imm       = {{20{instr[31]}}, instr[31:20]};
                op.alu_op    = alu_sel(funct3, instr[30], 1'b0);
            end
            op_l: begin
                op.reg_write = 1'b1;
                op.mem_read  = 1'b1;
                op.b_is_imm  = 1'b1;
                op.imm       = {{20{instr[31]}}, instr[31:20]};
                op.wb_src    = from_mem;
            end
            op_s: begin
                op.mem_write = 1'b1;
                op.b_is_imm  = 1'b1;
                op.imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                uses_rs2     = 1'b1;
            end
            op_b: begin
                op.branch = 1'b1;
                op.imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
                uses_rs2  = 1'b1;
            end
            op_lui: begin
                op.reg_write = 1'b1;
                op.b_is_imm  = 1'b1;
                op.imm       = {instr[31:12], 12'b0};
                op.alu_op    = alu_pass_b;
                uses_rs1     = 1'b0;
            end
            op_auipc: begin
                op.reg_write = 1'b1;
                op.a_is_pc   = 1'b1;
                op.b_is_imm  = 1'b1;
                op.imm       = {instr[31:12], 12'b0};
                uses_rs1     = 1'b0;
            end
            op_jal: begin
                op.reg_write = 1'b1;
                op.jal       = 1'b1;
                op.a_is_pc   = 1'b1;
                op.b_is_imm  = 1'b1;
                op.imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
                op.wb_src    = from_pc;
                uses_rs1     = 1'b0;
            end
            op_jalr: begin
                op.reg_write = 1'b1;
                op.jalr      = 1'b1;
                op.b_is_imm  = 1'b1;
                op.imm       = {{20{instr[31]}}, instr[31:20]};
                op.wb_src    = from_pc;
            end
            default: begin
                op.illegal = 1'b1;
                uses_rs1   = 1'b0;
            end
        endcase
    end

    // Busy bit drops in the writeback cycle, bypass supplies the value
    assign clr_mask = wb_en ? (NUM_REGS'(1) << wb_rd) : '0;
    assign busy_now = busy_q & ~clr_mask;

    // A pending write to rd also stalls so one busy bit per register stays exact
    assign hazard = (uses_rs1 && busy_now[rs1_addr]) ||
                    (uses_rs2 && busy_now[rs2_addr]) ||
                    (op.reg_write && busy_now[rd]);

    assign issue_ready = (!dec_valid || dec_ready) && !hazard;
    assign issue_fire  = issue_valid && issue_ready;
    assign set_mask    = (issue_fire && op.reg_write && rd != '0) ? (NUM_REGS'(1) << rd) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q    <= '0;
            dec_valid <= 1'b0;
        end else begin
            busy_q <= busy_now | set_mask;
            if (!dec_valid || dec_ready) begin
                dec_valid <= issue_fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            dec_op <= op;
        end
    end

    // A stalled source may only leave in the cycle result writes it back
    a_rs1_not_busy: assert property (@(posedge clk) disable iff (reset)
        issue_fire && uses_rs1 && busy_q[rs1_addr] |-> wb_en && wb_rd == rs1_addr);

    a_rs2_not_busy: assert property (@(posedge clk) disable iff (reset)
        issue_fire && uses_rs2 && busy_q[rs2_addr] |-> wb_en && wb_rd == rs2_addr);

endmodule

/* decode/rv_regfile.sv */
`timescale 1ns/100ps
`include "common/rv_settings.svh"

module rv_regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data,
    input  logic                      wb_en,
    input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
    input  logic [`RV_XLEN-1:0]       wb_data
);
    localparam int NUM_REGS = 1 << `RV_REG_ADDR_W;

    logic [`RV_XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin // x0 stays zero
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle write is visible to the reader
    assign rs1_data = (wb_en && wb_rd == rs1_addr && rs1_addr != '0) ? wb_data : regs[rs1_addr];
    assign rs2_data = (wb_en && wb_rd == rs2_addr && rs2_addr != '0) ? wb_data : regs[rs2_addr];

endmodule

/* execute/rv_execute.sv */
`timescale 1ns/100ps
`include "common/rv_settings.svh"

module rv_execute (
    input  logic             clk,
    input  logic             reset,
    input  logic             dec_valid,
    input  rv_pkg::dec_op_t  dec_op,
    output logic             dec_ready,
    output logic             exe_valid,
    output rv_pkg::exe_res_t exe_res,
    input  logic             exe_ready
);
    import rv_pkg::*;

    word_t    op_a;
    word_t    op_b;
    word_t    alu_out;
    word_t    pc_plus4;
    word_t    next_pc;
    logic [4:0] shamt;
    logic     taken;
    logic     dec_fire;
    exe_res_t res;

    assign op_a  = dec_op.a_is_pc ? dec_op.pc : dec_op.rs1_val;
    assign op_b  = dec_op.b_is_imm ? dec_op.imm : dec_op.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_op.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {31'b0, op_a < op_b};
            alu_xor:    alu_out = op_a ^ op_b;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $signed(op_a) >>> shamt;
            alu_or:     alu_out = op_a | op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // Branch compare always uses the two register values
    always_comb begin
        case (dec_op.funct3)
            3'b000:  taken = dec_op.rs1_val == dec_op.rs2_val;
            3'b001:  taken = dec_op.rs1_val != dec_op.rs2_val;
            3'b100:  taken = $signed(dec_op.rs1_val) < $signed(dec_op.rs2_val);
            3'b101:  taken = $signed(dec_op.rs1_val) >= $signed(dec_op.rs2_val);
            3'b110:  taken = dec_op.rs1_val < dec_op.rs2_val;
            3'b111:  taken = dec_op.rs1_val >= dec_op.rs2_val;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = dec_op.pc + 32'd4;

    always_comb begin
        if (dec_op.jalr) begin
            next_pc = {alu_out[31:1], 1'b0}; // rs1 + imm
        end else if (dec_op.jal) begin
            next_pc = alu_out; // pc + imm
        end else if (dec_op.branch && taken) begin
            next_pc = dec_op.pc + dec_op.imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        res            = '0;
        res.pc         = dec_op.pc;
        res.alu_res    = (dec_op.jal || dec_op.jalr) ? pc_plus4 : alu_out;
        res.store_data = dec_op.rs2_val;
        res.next_pc    = next_pc;
        res.funct3     = dec_op.funct3;
        res.rd         = dec_op.rd;
        res.wb_src     = dec_op.wb_src;
        res.reg_write  = dec_op.reg_write;
        res.mem_read   = dec_op.mem_read;
        res.mem_write  = dec_op.mem_write;
        res.illegal    = dec_op.illegal;
    end

    assign dec_ready = !exe_valid || exe_ready;
    assign dec_fire  = dec_valid && dec_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (dec_ready) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_fire) begin
            exe_res <= res;
        end
    end

    a_exe_hold: assert property (@(posedge clk) disable iff (reset)
        exe_valid && !exe_ready |=> exe_valid && $stable(exe_res));

endmodule

/* result/rv_result.sv */
`timescale 1ns/100ps
`include "common/rv_settings.svh"

module rv_result (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      exe_valid,
    input  rv_pkg::exe_res_t          exe_res,
    output logic                      exe_ready,
    output logic                      wb_en,
    output logic [`RV_REG_ADDR_W-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]       wb_data,
    output logic                      retire_valid,
    output rv_pkg::retire_t           retire,
    input  logic                      retire_ready
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    word_t            dmem [`RV_DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [1:0]       lane;
    word_t            rd_word;
    word_t            shifted;
    word_t            load_data;
    word_t            st_data;
    logic [3:0]       st_be;
    logic             exe_fire;
    retire_t          ret;

    assign idx     = exe_res.alu_res[2 +: IDX_W]; // Word address
    assign lane    = exe_res.alu_res[1:0];
    assign rd_word = dmem[idx];
    assign shifted = rd_word >> {lane, 3'b000};

    always_comb begin
        case (exe_res.funct3)
            3'b000:  load_data = {{24{shifted[7]}}, shifted[7:0]};   // lb
            3'b001:  load_data = {{16{shifted[15]}}, shifted[15:0]}; // lh
            3'b100:  load_data = {24'b0, shifted[7:0]};              // lbu
            3'b101:  load_data = {16'b0, shifted[15:0]};             // lhu
            default: load_data = rd_word;
        endcase
    end

    // Data replicated across lanes, enables pick the bytes
    always_comb begin
        case (exe_res.funct3[1:0])
            2'b00: begin
                st_be   = 4'b0001 << lane;
                st_data = {4{exe_res.store_data[7:0]}};
            end
            2'b01: begin
                st_be   = 4'b0011 << lane;
                st_data = {2{exe_res.store_data[15:0]}};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = exe_res.store_data;
            end
        endcase
    end

    assign exe_ready = !retire_valid || retire_ready;
    assign exe_fire  = exe_valid && exe_ready;

    always_ff @(posedge clk) begin
        if (exe_fire && exe_res.mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (st_be[i]) begin
                    dmem[idx][8*i +: 8] <= st_data[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        ret.pc      = exe_res.pc;
        ret.rd      = exe_res.rd;
        ret.rd_we   = exe_res.reg_write;
        ret.wdata   = (exe_res.wb_src == from_mem) ? load_data : exe_res.alu_res;
        ret.next_pc = exe_res.next_pc;
        ret.illegal = exe_res.illegal;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else if (exe_ready) begin
            retire_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_fire) begin
            retire <= ret;
        end
    end

    // Write port fires only with the retire handshake
    assign wb_en   = retire_valid && retire_ready && retire.rd_we && retire.rd != '0;
    assign wb_rd   = retire.rd;
    assign wb_data = retire.wdata;

    a_wb_x0: assert property (@(posedge clk) disable iff (reset)
        wb_en |-> wb_rd != '0 && retire_valid && !retire.illegal);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_slice testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module rv_slice_tb -o rv_slice_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_slice_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "^No errors$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* src.f */
+incdir+.
common/rv_pkg.sv
decode/rv_regfile.sv
decode/rv_decode.sv
execute/rv_execute.sv
result/rv_result.sv
src/rv_slice_top.sv
verif/rv_slice_tb.sv

/* src/rv_slice_top.sv */
`timescale 1ns/100ps
`include "common/rv_settings.svh"

module rv_slice_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            issue_valid,
    input  rv_pkg::issue_t  issue,
    output logic            issue_ready,
    output logic            retire_valid,
    output rv_pkg::retire_t retire,
    input  logic            retire_ready
);
    import rv_pkg::*;

    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic                      wb_en;
    logic [`RV_REG_ADDR_W-1:0] wb_rd;
    logic [`RV_XLEN-1:0]       wb_data;
    logic                      dec_valid;
    dec_op_t                   dec_op;
    logic                      dec_ready;
    logic                      exe_valid;
    exe_res_t                  exe_res;
    logic                      exe_ready;

    rv_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_ready   (dec_ready)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    rv_execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_ready (dec_ready),
        .exe_valid (exe_valid),
        .exe_res   (exe_res),
        .exe_ready (exe_ready)
    );

    rv_result u_result (
        .clk          (clk),
        .reset        (reset),
        .exe_valid    (exe_valid),
        .exe_res      (exe_res),
        .exe_ready    (exe_ready),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

endmodule

/* verif/rv_slice_tb.sv */
`timescale 1ns/100ps

module rv_slice_tb;
    import rv_pkg::*;

    localparam int VEC_COLS = 7;
    localparam int VEC_MAX  = 128;
    localparam int CLK_PER  = 100;

    logic     clk;
    logic     reset;
    logic     issue_valid;
    issue_t   issue;
    logic     issue_ready;
    logic     retire_valid;
    retire_t  retire;
    logic     retire_ready;

    logic [31:0] vec_mem [VEC_COLS*VEC_MAX];
    int          num_vec;
    int          retired;
    int          errors;
    logic        vec_loaded;
    integer      seed;

    rv_slice_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

    always #(CLK_PER/2) clk = ~clk;

    function automatic logic [31:0] vec_field(input int idx, input int col);
        return vec_mem[idx*VEC_COLS + col];
    endfunction

    function automatic logic [31:0] unloaded_word(input int addr);
        return 32'hbad0_0000 | 32'(addr);
    endfunction

    task automatic compare_field(input string name, input int idx, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("MISMATCH vec %0d pc %h %s expected %h actual %h",
                     idx, vec_field(idx, 0), name, exp, act);
        end
    endtask

    task automatic check_record(input int idx);
        logic [31:0] we_field;
        logic        exp_we;
        we_field = vec_field(idx, 3);
        exp_we   = we_field[0];
        compare_field("pc", idx, vec_field(idx, 0), retire.pc);
        compare_field("rd_we", idx, {31'b0, exp_we}, {31'b0, retire.rd_we});
        compare_field("next_pc", idx, vec_field(idx, 5), retire.next_pc);
        compare_field("illegal", idx, vec_field(idx, 6), {31'b0, retire.illegal});
        if (exp_we) begin // rd and wdata only carry meaning on a write
            compare_field("rd", idx, vec_field(idx, 2), {27'b0, retire.rd});
            compare_field("wdata", idx, vec_field(idx, 4), retire.wdata);
        end
    endtask

    // Random retire back-pressure near 70% ready
    always @(posedge clk) begin
        if (reset) begin
            retire_ready <= 1'b0;
        end else begin
            retire_ready <= ($unsigned($random(seed)) % 100) < 70;
        end
    end

    always @(posedge clk) begin
        if (!reset && retire_valid && retire_ready) begin
            assert (retired < num_vec) else begin
                errors++;
                $display("Extra retire record seen for pc %h", retire.pc);
            end
            if (retired < num_vec) begin
                check_record(retired);
            end
            retired++;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        <= 1'b1;
        issue_valid  <= 1'b0;
        issue        <= '0;
        retire_ready <= 1'b0;
        seed         = 32'h2799;
        num_vec      = 0;
        retired      = 0;
        errors       = 0;
        vec_loaded   = 1'b0;
        for (int a = 0; a < VEC_COLS*VEC_MAX; a++) begin
            vec_mem[a] = unloaded_word(a); // Marks rows the file leaves empty
        end
        $readmemh("verif/rv_slice_vectors.txt", vec_mem);
        while (num_vec < VEC_MAX &&
               vec_field(num_vec, 0) !== unloaded_word(num_vec * VEC_COLS)) begin
            num_vec++;
        end
        vec_loaded = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!retire_valid) else begin
            errors++;
            $display("retire_valid is high right after reset");
        end
        for (int i = 0; i < num_vec; i++) begin
            issue_valid <= 1'b1;
            issue       <= '{pc: vec_field(i, 0), instr: vec_field(i, 1)};
            do begin
                @(posedge clk);
            end while (!issue_ready);
        end
        issue_valid <= 1'b0;
        issue       <= '0;
        wait (retired >= num_vec);
        repeat (5) @(posedge clk); // Catch any duplicate record
        $display("Checked %0d of %0d records, %0d errors", retired, num_vec, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        wait (vec_loaded);
        #((num_vec * 20 + 8) * CLK_PER);
        errors++;
        $display("Timeout, only %0d of %0d records retired", retired, num_vec);
        $display("Checked %0d of %0d records, %0d errors", retired, num_vec, errors);
        $display("Errors found");
        $finish;
    end

endmodule

/* verif/rv_slice_vectors.txt */
// pc       instr    rd rd_we wdata    next_pc  illegal
// rd and wdata only checked when rd_we is 1
00000000 00500093 01 1 00000005 00000004 0
00000004 00708093 01 1 0000000c 00000008 0
00000008 ffd08093 01 1 00000009 0000000c 0
0000000c ff000113 02 1 fffffff0 00000010 0
00000010 002081b3 03 1 fffffff9 00000014 0
00000014 40208233 04 1 00000019 00000018 0
00000018 001122b3 05 1 00000001 0000001c 0
0000001c 00113333 06 1 00000000 00000020 0
00000020 0020c3b3 07 1 fffffff9 00000024 0
00000024 0020e433 08 1 fffffff9 00000028 0
00000028 0020f4b3 09 1 00000000 0000002c 0
0000002c 00109533 0a 1 00001200 00000030 0
00000030 00115633 0c 1 007fffff 00000034 0
00000034 401155b3 0b 1 ffffffff 00000038 0
00000038 40215693 0d 1 fffffffc 0000003c 0
0000003c 00409713 0e 1 00000090 00000040 0
00000040 fff0c793 0f 1 fffffff6 00000044 0
00000044 12345837 10 1 12345000 00000048 0
00000048 00001897 11 1 00001048 0000004c 0
0000004c 67880813 10 1 12345678 00000050 0
00000050 10000a13 14 1 00000100 00000054 0
00000054 010a2023 00 0 00000000 00000058 0
00000058 010a2223 00 0 00000000 0000005c 0
0000005c 00fa02a3 00 0 00000000 00000060 0
00000060 002a1123 00 0 00000000 00000064 0
00000064 000a2a83 15 1 fff05678 00000068 0
00000068 005a0b03 16 1 fffffff6 0000006c 0
0000006c 005a4b83 17 1 000000f6 00000070 0
00000070 002a1c03 18 1 fffffff0 00000074 0
00000074 002a5c83 19 1 0000fff0 00000078 0
00000078 004a2d03 1a 1 1234f678 0000007c 0
0000007c 00108463 00 0 00000000 00000084 0
00000084 00208463 00 0 00000000 00000088 0
00000088 00209463 00 0 00000000 00000090 0
00000090 00109463 00 0 00000000 00000094 0
00000094 00114463 00 0 00000000 0000009c 0
0000009c 0020c463 00 0 00000000 000000a0 0
000000a0 0020d463 00 0 00000000 000000a8 0
000000a8 00115463 00 0 00000000 000000ac 0
000000ac 0020e463 00 0 00000000 000000b4 0
000000b4 00116463 00 0 00000000 000000b8 0
000000b8 00117463 00 0 00000000 000000c0 0
000000c0 0020f463 00 0 00000000 000000c4 0
000000c4 00c002ef 05 1 000000c8 000000d0 0
000000d0 0e000313 06 1 000000e0 000000d4 0
000000d4 005303e7 07 1 000000d8 000000e4 0
000000e4 00108013 00 1 0000000a 000000e8 0
000000e8 00100db3 1b 1 00000009 000000ec 0
000000ec 0000000f 00 0 00000000 000000f0 1
000000f0 00000073 00 0 00000000 000000f4 1
000000f4 001d8e13 1c 1 0000000a 000000f8 0
